// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] phys_mask    = 32'h1fff_ffff;
    localparam logic [2:0]      uncached_seg = 3'b101;  // kseg1

    // bus size codes
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // bus data word, whole or per byte lane
    typedef union packed {
        logic [xlen-1:0] word;
        logic [3:0][7:0] bytes;  // bytes[0] is bits 7:0
    } data_word_u;

    typedef struct packed {
        logic                  is_load;
        logic                  sign_ext;
        logic [1:0]            size;
        logic [xlen-1:0]       base;
        logic [xlen-1:0]       offset;
        logic [xlen-1:0]       wdata;    // store data, right aligned
        logic [reg_addr_w-1:0] rd;
    } mem_op_t;

    typedef struct packed {
        logic            wr;
        logic [1:0]      size;
        logic [xlen-1:0] addr;
        logic [3:0]      wstrb;
        data_word_u      wdata;  // already in its byte lanes
        logic            cache;
    } bus_req_t;

    // what the write-back needs once data_ok returns
    typedef struct packed {
        logic                  is_load;
        logic                  sign_ext;
        logic [1:0]            size;
        logic [1:0]            addr_lo;
        logic [reg_addr_w-1:0] rd;
    } pend_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic            is_store;
        logic [xlen-1:0] bad_addr;  // sum before masking
    } exc_t;

endpackage

`default_nettype wire

// ==== source/lsu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              op_valid,
    input  lsu_pkg::mem_op_t  op,
    input  logic              grant,
    input  logic              data_addr_ok,
    output logic              issue_stall,
    output logic              data_req,
    output lsu_pkg::bus_req_t data_req_s,
    output lsu_pkg::pend_t    pend,
    output lsu_pkg::exc_t     exc
);

    logic [lsu_pkg::xlen-1:0]       sum;
    logic [lsu_pkg::xlen-1:0]       addr;
    logic [1:0]                     lo;
    logic                           misaligned;
    logic [3:0]                     strb;
    lsu_pkg::data_word_u            src;
    lsu_pkg::data_word_u            lanes;
    logic                           accept;
    logic                           addr_hs;
    logic                           held;
    logic                           sign_ext_q;
    logic [lsu_pkg::reg_addr_w-1:0] rd_q;
    lsu_pkg::bus_req_t              req_q;
    logic                           exc_valid;
    logic                           exc_is_store;
    logic [lsu_pkg::xlen-1:0]       exc_addr;

    assign sum  = op.base + op.offset;
    assign addr = sum & lsu_pkg::phys_mask;
    assign lo   = sum[1:0];
    assign src.word = op.wdata;

    always_comb begin
        misaligned = 1'b0;
        strb       = 4'b0001;
        case (op.size)
            lsu_pkg::size_half: begin
                misaligned = lo[0];
                strb       = 4'b0011;
            end
            lsu_pkg::size_word: begin
                misaligned = |lo;
                strb       = 4'b1111;
            end
            default: ;  // byte, never misaligned
        endcase
        strb = strb << lo;
    end

    // move each store byte up into the lane its address selects
    always_comb begin
        logic [1:0] k;
        for (int i = 0; i < 4; i++) begin
            k = 2'(i) - lo;
            lanes.bytes[i] = strb[i] ? src.bytes[k] : 8'h00;
        end
    end

    assign addr_hs     = data_req && data_addr_ok;
    assign issue_stall = held && !addr_hs;  // free again in the addr_ok cycle
    assign accept      = op_valid && !issue_stall;
    assign data_req    = held && grant;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            held      <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            exc_valid <= accept && misaligned;
            if (accept && !misaligned)
                held <= 1'b1;
            else if (addr_hs)
                held <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_q.wr     <= !op.is_load;
            req_q.size   <= op.size;
            req_q.addr   <= addr;
            req_q.wstrb  <= strb;
            req_q.wdata  <= lanes;
            req_q.cache  <= sum[31:29] != lsu_pkg::uncached_seg;
            sign_ext_q   <= op.sign_ext;
            rd_q         <= op.rd;
            exc_is_store <= !op.is_load;
            exc_addr     <= sum;
        end
    end

    assign data_req_s = req_q;
    assign pend = '{is_load: !req_q.wr, sign_ext: sign_ext_q, size: req_q.size,
                    addr_lo: req_q.addr[1:0], rd: rd_q};
    assign exc  = '{valid: exc_valid, is_store: exc_is_store, bad_addr: exc_addr};

endmodule

`default_nettype wire

// ==== source/lsu_bus_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_tracker (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           data_addr_ok,
    input  logic           data_data_ok,
    input  lsu_pkg::pend_t pend_in,
    output logic           grant,
    output lsu_pkg::pend_t pend_out
);

    logic           busy;    // one access handed over, data_ok not yet seen
    lsu_pkg::pend_t pend_q;

    // addr_ok wins over data_ok, so a back to back access stays busy
    always_ff @(posedge aclk) begin
        if (!aresetn)
            busy <= 1'b0;
        else if (data_addr_ok)
            busy <= 1'b1;
        else if (data_data_ok)
            busy <= 1'b0;
    end

    always_ff @(posedge aclk) begin
        if (data_addr_ok)
            pend_q <= pend_in;
    end

    // the completing access may overlap a new request
    assign grant = !busy || data_data_ok;

    always_comb begin
        pend_out         = pend_q;
        pend_out.is_load = pend_q.is_load && busy;  // nothing outstanding, no load
    end

endmodule

`default_nettype wire

// ==== source/lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                data_data_ok,
    input  lsu_pkg::data_word_u data_rdata,
    input  lsu_pkg::pend_t      pend,
    output lsu_pkg::wb_t        wb
);

    logic [7:0]                     byte_sel;
    logic [15:0]                    half_sel;
    logic [lsu_pkg::xlen-1:0]       ext;
    logic                           load_done;
    logic                           wb_valid;
    logic [lsu_pkg::reg_addr_w-1:0] wb_rd;
    logic [lsu_pkg::xlen-1:0]       wb_data;

    always_comb begin
        byte_sel = data_rdata.bytes[pend.addr_lo];
        // halfwords are aligned, bit 1 picks the upper or lower pair
        half_sel = pend.addr_lo[1] ? {data_rdata.bytes[3], data_rdata.bytes[2]}
                                   : {data_rdata.bytes[1], data_rdata.bytes[0]};
        case (pend.size)
            lsu_pkg::size_byte: ext = {{24{pend.sign_ext & byte_sel[7]}}, byte_sel};
            lsu_pkg::size_half: ext = {{16{pend.sign_ext & half_sel[15]}}, half_sel};
            default:            ext = data_rdata.word;
        endcase
    end

    assign load_done = data_data_ok && pend.is_load;  // store data_ok carries nothing

    always_ff @(posedge aclk) begin
        if (!aresetn)
            wb_valid <= 1'b0;
        else
            wb_valid <= load_done;
    end

    always_ff @(posedge aclk) begin
        if (load_done) begin
            wb_rd   <= pend.rd;
            wb_data <= ext;
        end
    end

    assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                op_valid,
    input  lsu_pkg::mem_op_t    op,
    output logic                issue_stall,

    output logic                data_req,
    output lsu_pkg::bus_req_t   data_req_s,
    input  logic                data_addr_ok,
    input  logic                data_data_ok,
    input  lsu_pkg::data_word_u data_rdata,

    output lsu_pkg::wb_t        wb,
    output lsu_pkg::exc_t       exc
);

    logic           grant;
    lsu_pkg::pend_t issue_pend;  // held request, taken on addr_ok
    lsu_pkg::pend_t done_pend;   // outstanding access, used on data_ok

    lsu_issue u_issue (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .op_valid     (op_valid),
        .op           (op),
        .grant        (grant),
        .data_addr_ok (data_addr_ok),
        .issue_stall  (issue_stall),
        .data_req     (data_req),
        .data_req_s   (data_req_s),
        .pend         (issue_pend),
        .exc          (exc)
    );

    lsu_bus_tracker u_tracker (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .pend_in      (issue_pend),
        .grant        (grant),
        .pend_out     (done_pend)
    );

    lsu_load_align u_load_align (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .pend         (done_pend),
        .wb           (wb)
    );

endmodule

`default_nettype wire

// ==== dv/lsu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
    input logic                aclk,
    input logic                aresetn,
    input logic                data_req,
    input lsu_pkg::bus_req_t   data_req_s,
    input logic                data_addr_ok,
    input logic                data_data_ok,
    input lsu_pkg::wb_t        wb,
    input lsu_pkg::exc_t       exc
);

    logic busy_q;  // access handed over, data_ok still to come

    always_ff @(posedge aclk) begin
        if (!aresetn)
            busy_q <= 1'b0;
        else if (data_req && data_addr_ok)
            busy_q <= 1'b1;
        else if (data_data_ok)
            busy_q <= 1'b0;
    end

    req_held_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        data_req && !data_addr_ok |=> data_req && $stable(data_req_s))
        else $error("request dropped or changed before addr_ok");

    no_req_while_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        data_req |-> (!busy_q || data_data_ok))
        else $error("request raised while an access is outstanding");

    exc_without_req: assert property (@(posedge aclk) disable iff (!aresetn)
        exc.valid |-> !data_req)
        else $error("address error and bus request from one op");

    // one write-back cycle per completing access
    wb_after_data_ok: assert property (@(posedge aclk) disable iff (!aresetn)
        wb.valid |-> $past(data_data_ok && busy_q))
        else $error("write-back without a completing access");

endmodule

`default_nettype wire

// ==== dv/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    logic                aclk;
    logic                aresetn;
    logic                op_valid;
    lsu_pkg::mem_op_t    op;
    logic                issue_stall;
    logic                data_req;
    lsu_pkg::bus_req_t   data_req_s;
    logic                data_addr_ok;
    logic                data_data_ok;
    lsu_pkg::data_word_u data_rdata;
    lsu_pkg::wb_t        wb;
    lsu_pkg::exc_t       exc;

    lsu_pkg::mem_op_t  ops[$];
    logic              exc_flag[$];
    logic [31:0]       exp_data[$];
    lsu_pkg::bus_req_t req_q[$];
    lsu_pkg::wb_t      wb_q[$];
    lsu_pkg::exc_t     exc_q[$];
    string             req_names[$];
    string             wb_names[$];
    string             exc_names[$];

    logic [31:0]       mem [64];
    integer            seed = 32'h667ef160;
    int                mismatches = 0;
    int                other_errs = 0;
    int                a_wait;
    int                d_wait;
    logic              busy;
    lsu_pkg::bus_req_t out_req;

    lsu_top DUT (.*);

    bind lsu_top lsu_assertions u_assertions (
        .aclk(aclk), .aresetn(aresetn), .data_req(data_req), .data_req_s(data_req_s),
        .data_addr_ok(data_addr_ok), .data_data_ok(data_data_ok), .wb(wb), .exc(exc)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic int rand_delay();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    // request as the bus should see it, built from the op alone
    function automatic lsu_pkg::bus_req_t expect_req(lsu_pkg::mem_op_t o);
        logic [31:0]       s;
        logic [3:0]        m;
        lsu_pkg::bus_req_t r;
        s = o.base + o.offset;
        case (o.size)
            lsu_pkg::size_byte: m = 4'b0001 << s[1:0];
            lsu_pkg::size_half: m = 4'b0011 << s[1:0];
            default:            m = 4'b1111;
        endcase
        r.wr = !o.is_load;
        r.size = o.size;
        r.addr = {3'b000, s[28:0]};
        r.wstrb = m;
        r.wdata.word = o.wdata << (8 * s[1:0]);
        for (int j = 0; j < 4; j++) begin
            if (!m[j])
                r.wdata.bytes[j] = 8'h00;
        end
        r.cache = s[31:29] != 3'b101;  // kseg1 is uncached
        return r;
    endfunction

    task automatic check_wb(input string name, input lsu_pkg::wb_t e, input lsu_pkg::wb_t a);
        if (a !== e) begin
            mismatches++;
            $display("mismatch %s: expected wb %h, actual %h", name, e, a);
        end
    endtask

    task automatic check_req(input string name, input lsu_pkg::bus_req_t e,
                             input lsu_pkg::bus_req_t a);
        if (a !== e) begin
            mismatches++;
            $display("mismatch %s: expected req %h, actual %h", name, e, a);
        end
    endtask

    task automatic check_exc(input string name, input lsu_pkg::exc_t e, input lsu_pkg::exc_t a);
        if (a !== e) begin
            mismatches++;
            $display("mismatch %s: expected exc %h, actual %h", name, e, a);
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f[9];
        lsu_pkg::mem_op_t o;
        fd = $fopen("dv/lsu_stim.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the stimulus file dv/lsu_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0)
                break;
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n != 9)
                continue;
            o.is_load  = f[0][0];
            o.sign_ext = f[1][0];
            o.size     = f[2][1:0];
            o.base     = f[3];
            o.offset   = f[4];
            o.wdata    = f[5];
            o.rd       = f[6][4:0];
            ops.push_back(o);
            exc_flag.push_back(f[7][0]);
            exp_data.push_back(f[8]);
        end
        $fclose(fd);
    endtask

    // what the accepted op i must produce later
    task automatic push_expect(input int i);
        lsu_pkg::mem_op_t o;
        string            name;
        o = ops[i];
        name = $sformatf("op%0d", i);
        if (exc_flag[i]) begin
            exc_q.push_back('{valid: 1'b1, is_store: !o.is_load, bad_addr: o.base + o.offset});
            exc_names.push_back(name);
        end else begin
            req_q.push_back(expect_req(o));
            req_names.push_back(name);
            if (o.is_load) begin
                wb_q.push_back('{valid: 1'b1, rd: o.rd, data: exp_data[i]});
                wb_names.push_back(name);
            end
        end
    endtask

    // bus responder with random addr_ok and data_ok delays
    always @(negedge aclk) begin
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        if (!aresetn) begin
            busy = 1'b0;
            a_wait = 0;
        end else begin
            if (busy) begin
                if (d_wait == 0) begin
                    data_data_ok = 1'b1;
                    busy = 1'b0;
                    if (out_req.wr) begin
                        for (int j = 0; j < 4; j++)
                            if (out_req.wstrb[j])
                                mem[out_req.addr[7:2]][8*j +: 8] = out_req.wdata.bytes[j];
                    end else begin
                        data_rdata.word = mem[out_req.addr[7:2]];
                    end
                end else begin
                    d_wait--;
                end
            end
            #1;
            if (data_req) begin
                if (a_wait == 0) begin
                    data_addr_ok = 1'b1;
                    if (req_q.size() == 0) begin
                        other_errs++;
                        $display("bus request made with no request expected");
                    end else begin
                        check_req(req_names.pop_front(), req_q.pop_front(), data_req_s);
                    end
                    out_req = data_req_s;
                    busy = 1'b1;
                    d_wait = rand_delay();
                    a_wait = rand_delay();
                    #1;
                    if (issue_stall) begin
                        other_errs++;
                        $display("issue_stall stayed high in the addr_ok cycle");
                    end
                end else begin
                    a_wait--;
                end
            end
        end
    end

    // registered outputs, sampled mid cycle
    always @(negedge aclk) begin
        if (aresetn && wb.valid) begin
            if (wb_q.size() == 0) begin
                other_errs++;
                $display("write-back seen with no load outstanding");
            end else begin
                check_wb(wb_names.pop_front(), wb_q.pop_front(), wb);
            end
        end
        if (aresetn && exc.valid) begin
            if (exc_q.size() == 0) begin
                other_errs++;
                $display("address error raised for an aligned op");
            end else begin
                check_exc(exc_names.pop_front(), exc_q.pop_front(), exc);
            end
        end
    end

    initial begin
        int waited;
        aresetn = 1'b0;
        op_valid = 1'b0;
        op = '0;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        data_rdata = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
        load_stim();
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        for (int i = 0; i < ops.size(); i++) begin
            @(negedge aclk);
            op_valid = 1'b1;
            op = ops[i];
            #2;
            waited = 0;
            while (issue_stall && waited < 64) begin
                @(negedge aclk);
                #2;
                waited++;
            end
            if (issue_stall) begin
                other_errs++;
                $display("timeout: op%0d was never accepted", i);
                break;
            end
            push_expect(i);
        end
        @(negedge aclk);
        op_valid = 1'b0;

        waited = 0;
        while ((req_q.size() + wb_q.size() + exc_q.size()) != 0 && waited < 200) begin
            @(negedge aclk);
            waited++;
        end
        if ((req_q.size() + wb_q.size() + exc_q.size()) != 0) begin
            other_errs++;
            $display("timeout: %0d requests, %0d write-backs, %0d errors never seen",
                     req_q.size(), wb_q.size(), exc_q.size());
        end
        repeat (4) @(negedge aclk);

        $display("ops %0d, mismatches %0d, other errors %0d", ops.size(), mismatches,
                 other_errs);
        if (mismatches == 0 && other_errs == 0 && ops.size() != 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/lsu_pkg.sv
source/lsu_issue.sv
source/lsu_bus_tracker.sv
source/lsu_load_align.sv
source/lsu_top.sv
dv/lsu_assertions.sv
dv/tb_lsu.sv

// ==== Makefile ====
.PHONY: lint sim clean

TOP := tb_lsu

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== dv/lsu_stim.txt ====
# is_load sign_ext size base offset wdata rd exc exp_data   (all hex)
# exc=1 means an address error is expected; exp_data only matters for loads
0 0 2 80000000 00000010 11223344 00 0 00000000
0 0 2 a0000000 00000020 8899aabb 00 0 00000000
0 0 0 80000000 00000011 000000ee 00 0 00000000
0 0 1 80000000 00000012 0000f00d 00 0 00000000
1 0 2 80000000 00000010 00000000 01 0 f00dee44
1 1 0 80000000 00000011 00000000 02 0 ffffffee
1 0 0 80000000 00000011 00000000 03 0 000000ee
1 1 1 80000000 00000012 00000000 04 0 fffff00d
1 0 1 80000000 00000010 00000000 05 0 0000ee44
1 1 0 80000000 00000010 00000000 06 0 00000044
1 1 0 a0000000 00000023 00000000 07 0 ffffff88
1 0 1 a0000000 00000022 00000000 08 0 00008899
0 0 1 80000000 00000031 0000beef 00 1 00000000
1 0 2 bfc00000 00000002 00000000 0d 1 00000000
0 0 2 00000000 0000003c cafebabe 00 0 00000000
1 0 2 00000040 fffffffc 00000000 09 0 cafebabe
0 0 2 80000000 00000041 01020304 00 1 00000000
1 1 0 00000000 0000003e 00000000 0a 0 fffffffe
1 1 1 00000000 0000003c 00000000 0b 0 ffffbabe
0 0 0 a0000022 00000000 12345677 00 0 00000000
1 0 2 a0000000 00000020 00000000 0c 0 8877aabb
